/* source/rv32_decoder_cfg.svh */
`ifndef RV32_DECODER_CFG_SVH
`define RV32_DECODER_CFG_SVH

// Datapath widths
`define DATA_WIDTH     32
`define REG_ADDR_WIDTH 5
`define ALU_OP_WIDTH   4
`define LSU_CTRL_WIDTH 4

// Major opcodes handled by the decoder
`define OPCODE_LOAD  7'b0000011
`define OPCODE_STORE 7'b0100011
`define OPCODE_OPIMM 7'b0010011
`define OPCODE_OP    7'b0110011
`define OPCODE_LUI   7'b0110111
`define OPCODE_AUIPC 7'b0010111
`define OPCODE_JAL   7'b1101111

`define ALU_OP_ADD  4'b0000
`define FUNCT3_SLL  3'b001
`define FUNCT3_SRX  3'b101   // SRLI and SRAI, bit 30 tells them apart
`define LINK_OFFSET 4        // Return address is PC + 4

`endif

/* source/rv32_decoder_pkg.sv */
`include "rv32_decoder_cfg.svh"

package rv32_decoder_pkg;

  typedef logic [`DATA_WIDTH-1:0]     data_t;
  typedef logic [`REG_ADDR_WIDTH-1:0] reg_addr_t;
  typedef logic [`ALU_OP_WIDTH-1:0]   alu_op_t;
  typedef logic [`LSU_CTRL_WIDTH-1:0] lsu_ctrl_t;   // {store, funct3}

  // Immediate layout selected by the opcode decode
  typedef enum logic [2:0] {
    FMT_NONE,
    FMT_I,
    FMT_SHAMT,
    FMT_S,
    FMT_U,
    FMT_J,
    FMT_LINK
  } imm_fmt_t;

  // Decoder control states, one-hot
  typedef enum logic [5:0] {
    S_OK         = 6'b000001,
    S_STALL      = 6'b000010,
    S_JAL        = 6'b000100,
    S_JAL_WAIT_1 = 6'b001000,
    S_JAL_WAIT_2 = 6'b010000,
    S_ERROR      = 6'b100000
  } dec_state_t;

  // J-type offset, bits scattered over the instruction word
  function automatic data_t j_imm(data_t instr);
    return {{(`DATA_WIDTH-21){instr[31]}}, instr[31], instr[19:12], instr[20],
            instr[30:21], 1'b0};
  endfunction

endpackage

/* source/imm_gen.sv */
`include "rv32_decoder_cfg.svh"

module imm_gen import rv32_decoder_pkg::*; (
  input  data_t    instr_i,
  input  imm_fmt_t imm_fmt_i,
  output data_t    imm_o
);

  logic sign;

  assign sign = instr_i[31];   // All signed formats keep the sign in bit 31

  always_comb begin
    case (imm_fmt_i)
      FMT_I: begin
        imm_o = {{(`DATA_WIDTH-12){sign}}, instr_i[31:20]};
      end
      FMT_SHAMT: begin
        imm_o = {{(`DATA_WIDTH-5){1'b0}}, instr_i[24:20]};   // Never sign-extended
      end
      FMT_S: begin
        imm_o = {{(`DATA_WIDTH-12){sign}}, instr_i[31:25], instr_i[11:7]};
      end
      FMT_U: begin
        imm_o = {instr_i[31:12], 12'b0};
      end
      FMT_J: begin
        imm_o = j_imm(instr_i);
      end
      FMT_LINK: begin
        // JAL writes PC + 4, ALU adds this to the PC
        imm_o = data_t'(`LINK_OFFSET);
      end
      default: begin
        imm_o = '0;
      end
    endcase
  end

endmodule

/* source/ctrl_decode.sv */
`include "rv32_decoder_cfg.svh"

module ctrl_decode import rv32_decoder_pkg::*; (
  input  data_t     instr_i,
  output alu_op_t   alu_sel_o,
  output logic      alu_op_a_o,
  output logic      alu_op_b_o,
  output logic      use_pc_o,
  output logic      alu_wb_o,
  output logic      lsu_valid_o,
  output lsu_ctrl_t lsu_ctrl_o,
  output reg_addr_t rs1_o,
  output reg_addr_t rs2_o,
  output reg_addr_t rd_o,
  output logic      use_rs1_o,
  output logic      use_rs2_o,
  output logic      is_jal_o,
  output logic      is_store_o,
  output logic      illegal_o,
  output imm_fmt_t  imm_fmt_o
);

  logic [6:0] opcode;
  logic [2:0] funct3;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];

  // S-type has no rd, the field is imm[4:0] there
  assign rd_o       = instr_i[11:7];
  assign rs1_o      = use_rs1_o ? instr_i[19:15] : '0;
  assign rs2_o      = use_rs2_o ? instr_i[24:20] : '0;
  assign lsu_ctrl_o = {is_store_o, funct3};

  //////////////////////////////////////////////////////////////////////
  // Opcode decode
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    alu_sel_o   = `ALU_OP_ADD;
    alu_op_a_o  = 1'b0;
    alu_op_b_o  = 1'b0;
    use_pc_o    = 1'b0;
    alu_wb_o    = 1'b0;
    lsu_valid_o = 1'b0;
    use_rs1_o   = 1'b0;
    use_rs2_o   = 1'b0;
    is_jal_o    = 1'b0;
    is_store_o  = 1'b0;
    illegal_o   = 1'b0;
    imm_fmt_o   = FMT_NONE;

    case (opcode)
      `OPCODE_OP: begin
        alu_sel_o  = {instr_i[30], funct3};   // Bit 30 picks SUB and SRA
        alu_op_a_o = 1'b1;
        alu_op_b_o = 1'b1;
        use_rs1_o  = 1'b1;
        use_rs2_o  = 1'b1;
        alu_wb_o   = 1'b1;
      end
      `OPCODE_OPIMM: begin
        alu_op_a_o = 1'b1;
        use_rs1_o  = 1'b1;
        alu_wb_o   = 1'b1;
        if (funct3 == `FUNCT3_SLL || funct3 == `FUNCT3_SRX) begin
          alu_sel_o = {instr_i[30], funct3};
          imm_fmt_o = FMT_SHAMT;
        end else begin
          alu_sel_o = {1'b0, funct3};   // No SUBI, bit 30 is immediate data
          imm_fmt_o = FMT_I;
        end
      end
      `OPCODE_LOAD: begin
        alu_op_a_o  = 1'b1;   // Address is rs1 + imm
        use_rs1_o   = 1'b1;
        lsu_valid_o = 1'b1;
        imm_fmt_o   = FMT_I;
      end
      `OPCODE_STORE: begin
        alu_op_a_o  = 1'b1;
        use_rs1_o   = 1'b1;
        use_rs2_o   = 1'b1;   // Store data
        lsu_valid_o = 1'b1;
        is_store_o  = 1'b1;
        imm_fmt_o   = FMT_S;
      end
      `OPCODE_LUI: begin
        alu_op_a_o = 1'b1;   // rs1 stays x0, so result is the immediate
        alu_wb_o   = 1'b1;
        imm_fmt_o  = FMT_U;
      end
      `OPCODE_AUIPC: begin
        alu_op_a_o = 1'b1;
        use_pc_o   = 1'b1;
        alu_wb_o   = 1'b1;
        imm_fmt_o  = FMT_U;
      end
      `OPCODE_JAL: begin
        use_pc_o  = 1'b1;   // Link value PC + 4
        alu_wb_o  = 1'b1;
        is_jal_o  = 1'b1;
        imm_fmt_o = FMT_LINK;
      end
      default: begin
        // BRANCH, JALR, SYSTEM, MISC-MEM and unknown opcodes
        illegal_o = 1'b1;
      end
    endcase
  end

endmodule

/* source/hazard_fsm.sv */
module hazard_fsm import rv32_decoder_pkg::*; (
  input  logic      clk_i,
  input  logic      rstn_i,
  input  logic      instr_valid_i,
  input  data_t     instr_i,
  input  reg_addr_t rs1_i,
  input  reg_addr_t rs2_i,
  input  logic      use_rs1_i,
  input  logic      use_rs2_i,
  input  reg_addr_t rd_i,
  input  logic      is_jal_i,
  input  logic      is_store_i,
  input  logic      illegal_i,
  output logic      ready_o,
  output logic      issue_o,
  output logic      jmp_o,
  output data_t     jmp_addr_o
);

  dec_state_t state_q;
  dec_state_t state_d;
  reg_addr_t  prev_rd_q;   // Destination of the last valid instruction
  logic       rs1_hit;
  logic       rs2_hit;
  logic       hazard;

  // x0 never creates a dependency
  assign rs1_hit = use_rs1_i && (rs1_i != '0) && (rs1_i == prev_rd_q);
  assign rs2_hit = use_rs2_i && (rs2_i != '0) && (rs2_i == prev_rd_q);
  assign hazard  = (rs1_hit || rs2_hit) && (state_q != S_STALL);

  //////////////////////////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    case (state_q)
      S_JAL:        state_d = S_JAL_WAIT_1;
      S_JAL_WAIT_1: state_d = S_JAL_WAIT_2;
      S_ERROR:      state_d = S_ERROR;   // Only reset leaves
      default: begin
        // S_OK, S_STALL and S_JAL_WAIT_2 all decode a fresh instruction
        if (!instr_valid_i) begin
          state_d = S_OK;
        end else if (illegal_i) begin
          state_d = S_ERROR;
        end else if (hazard) begin
          state_d = S_STALL;
        end else if (is_jal_i) begin
          state_d = S_JAL;
        end else begin
          state_d = S_OK;
        end
      end
    endcase
  end

  // Outputs follow the next state so fetch sees them in the same cycle
  assign ready_o    = (state_d == S_OK) || (state_d == S_JAL_WAIT_2);
  assign issue_o    = instr_valid_i && ready_o;
  assign jmp_o      = (state_d == S_JAL);
  assign jmp_addr_o = jmp_o ? j_imm(instr_i) : '0;

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      state_q   <= S_OK;
      prev_rd_q <= '0;
    end else begin
      state_q <= state_d;
      if (instr_valid_i) begin
        prev_rd_q <= (is_store_i || illegal_i) ? '0 : rd_i;
      end
    end
  end

  a_jmp_one_cycle: assert property (@(posedge clk_i) disable iff (!rstn_i)
    jmp_o |=> !jmp_o);

  a_error_sticky: assert property (@(posedge clk_i) disable iff (!rstn_i)
    (state_q == S_ERROR) |=> (state_q == S_ERROR));

endmodule

/* source/id_ex_regs.sv */
module id_ex_regs import rv32_decoder_pkg::*; (
  input  logic      clk_i,
  input  logic      rstn_i,
  input  logic      issue_i,
  input  logic      instr_valid_i,
  input  alu_op_t   alu_sel_i,
  input  logic      alu_op_a_i,
  input  logic      alu_op_b_i,
  input  logic      use_pc_i,
  input  logic      alu_wb_i,
  input  logic      lsu_valid_i,
  input  lsu_ctrl_t lsu_ctrl_i,
  input  reg_addr_t rs1_i,
  input  reg_addr_t rs2_i,
  input  reg_addr_t rd_i,
  input  data_t     imm_i,
  input  logic      illegal_i,
  input  data_t     instr_addr_i,
  output alu_op_t   alu_sel_o,
  output logic      alu_op_a_o,
  output logic      alu_op_b_o,
  output logic      use_pc_o,
  output logic      alu_wb_o,
  output logic      lsu_valid_o,
  output lsu_ctrl_t lsu_ctrl_o,
  output reg_addr_t rf_addr_a_o,
  output reg_addr_t rf_addr_b_o,
  output reg_addr_t rd_o,
  output data_t     imm_o,
  output data_t     instr_addr_o,
  output logic      illegal_instr_o
);

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      alu_sel_o    <= '0;
      alu_op_a_o   <= 1'b0;
      alu_op_b_o   <= 1'b0;
      use_pc_o     <= 1'b0;
      alu_wb_o     <= 1'b0;
      lsu_valid_o  <= 1'b0;
      lsu_ctrl_o   <= '0;
      rf_addr_a_o  <= '0;
      rf_addr_b_o  <= '0;
      rd_o         <= '0;
      imm_o        <= '0;
      instr_addr_o <= '0;
    end else if (issue_i) begin
      alu_sel_o    <= alu_sel_i;
      alu_op_a_o   <= alu_op_a_i;
      alu_op_b_o   <= alu_op_b_i;
      use_pc_o     <= use_pc_i;
      alu_wb_o     <= alu_wb_i;
      lsu_valid_o  <= lsu_valid_i;
      lsu_ctrl_o   <= lsu_ctrl_i;
      rf_addr_a_o  <= rs1_i;
      rf_addr_b_o  <= rs2_i;
      rd_o         <= rd_i;
      imm_o        <= imm_i;
      instr_addr_o <= instr_addr_i;
    end else begin
      // Bubble, only the strobes drop
      use_pc_o    <= 1'b0;
      alu_wb_o    <= 1'b0;
      lsu_valid_o <= 1'b0;
    end
  end

  // Flag stays up until reset
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      illegal_instr_o <= 1'b0;
    end else if (instr_valid_i) begin
      illegal_instr_o <= illegal_instr_o | illegal_i;
    end
  end

  a_wb_lsu_excl: assert property (@(posedge clk_i) disable iff (!rstn_i)
    !(alu_wb_o && lsu_valid_o));

endmodule

/* source/rv32_decoder.sv */
module rv32_decoder import rv32_decoder_pkg::*; (
  input  logic      clk_i,
  input  logic      rstn_i,
  input  data_t     instr_i,
  input  data_t     instr_addr_i,
  input  logic      instr_valid_i,
  output logic      ready_o,
  output logic      jmp_o,
  output data_t     jmp_addr_o,
  output alu_op_t   alu_sel_o,
  output logic      alu_op_a_o,
  output logic      alu_op_b_o,
  output logic      use_pc_o,
  output logic      alu_wb_o,
  output logic      lsu_valid_o,
  output lsu_ctrl_t lsu_ctrl_o,
  output reg_addr_t rf_addr_a_o,
  output reg_addr_t rf_addr_b_o,
  output reg_addr_t rd_o,
  output data_t     imm_o,
  output data_t     instr_addr_o,
  output logic      illegal_instr_o
);

  // Decoded fields before the output register
  alu_op_t   dec_alu_sel;
  logic      dec_alu_op_a;
  logic      dec_alu_op_b;
  logic      dec_use_pc;
  logic      dec_alu_wb;
  logic      dec_lsu_valid;
  lsu_ctrl_t dec_lsu_ctrl;
  reg_addr_t dec_rs1;
  reg_addr_t dec_rs2;
  reg_addr_t dec_rd;
  logic      dec_use_rs1;
  logic      dec_use_rs2;
  logic      dec_is_jal;
  logic      dec_is_store;
  logic      dec_illegal;
  imm_fmt_t  dec_imm_fmt;
  data_t     dec_imm;
  logic      issue;

  ctrl_decode ctrl_decode0 (
    .instr_i     (instr_i),
    .alu_sel_o   (dec_alu_sel),
    .alu_op_a_o  (dec_alu_op_a),
    .alu_op_b_o  (dec_alu_op_b),
    .use_pc_o    (dec_use_pc),
    .alu_wb_o    (dec_alu_wb),
    .lsu_valid_o (dec_lsu_valid),
    .lsu_ctrl_o  (dec_lsu_ctrl),
    .rs1_o       (dec_rs1),
    .rs2_o       (dec_rs2),
    .rd_o        (dec_rd),
    .use_rs1_o   (dec_use_rs1),
    .use_rs2_o   (dec_use_rs2),
    .is_jal_o    (dec_is_jal),
    .is_store_o  (dec_is_store),
    .illegal_o   (dec_illegal),
    .imm_fmt_o   (dec_imm_fmt)
  );

  imm_gen imm_gen0 (
    .instr_i   (instr_i),
    .imm_fmt_i (dec_imm_fmt),
    .imm_o     (dec_imm)
  );

  // Clock, reset, fetch inputs and jump outputs connect by name
  hazard_fsm hazard_fsm0 (
    .rs1_i      (dec_rs1),
    .rs2_i      (dec_rs2),
    .use_rs1_i  (dec_use_rs1),
    .use_rs2_i  (dec_use_rs2),
    .rd_i       (dec_rd),
    .is_jal_i   (dec_is_jal),
    .is_store_i (dec_is_store),
    .illegal_i  (dec_illegal),
    .issue_o    (issue),
    .*
  );

  // Registered outputs connect by name to the top ports
  id_ex_regs id_ex_regs0 (
    .issue_i     (issue),
    .alu_sel_i   (dec_alu_sel),
    .alu_op_a_i  (dec_alu_op_a),
    .alu_op_b_i  (dec_alu_op_b),
    .use_pc_i    (dec_use_pc),
    .alu_wb_i    (dec_alu_wb),
    .lsu_valid_i (dec_lsu_valid),
    .lsu_ctrl_i  (dec_lsu_ctrl),
    .rs1_i       (dec_rs1),
    .rs2_i       (dec_rs2),
    .rd_i        (dec_rd),
    .imm_i       (dec_imm),
    .illegal_i   (dec_illegal),
    .*
  );

endmodule

/* tests/tb_rv32_decoder.sv */
module tb_rv32_decoder import rv32_decoder_pkg::*; ();

  localparam int NUM_ROWS   = 19;
  localparam int MAX_CYCLES = NUM_ROWS * 6 + 50;

  typedef struct packed {
    data_t      instr;
    alu_op_t    alu_sel;
    logic [4:0] flags;      // {op_a, op_b, use_pc, wb, lsu_valid}
    lsu_ctrl_t  lsu_ctrl;
    reg_addr_t  ra;
    reg_addr_t  rb;
    reg_addr_t  rd;
    data_t      imm;
    logic [1:0] hold;       // Cycles with ready low before issue
    logic       gap;        // Idle cycles follow this row
  } row_t;

  logic      clk_i;
  logic      rstn_i;
  data_t     instr_i;
  data_t     instr_addr_i;
  logic      instr_valid_i;
  logic      ready_o;
  logic      jmp_o;
  data_t     jmp_addr_o;
  alu_op_t   alu_sel_o;
  logic      alu_op_a_o;
  logic      alu_op_b_o;
  logic      use_pc_o;
  logic      alu_wb_o;
  logic      lsu_valid_o;
  lsu_ctrl_t lsu_ctrl_o;
  reg_addr_t rf_addr_a_o;
  reg_addr_t rf_addr_b_o;
  reg_addr_t rd_o;
  data_t     imm_o;
  data_t     instr_addr_o;
  logic      illegal_instr_o;

  row_t  tbl [NUM_ROWS];
  data_t exp_jmp [NUM_ROWS];   // Jump offset that JAL rows expect on jmp_o
  int    errors = 0;
  int    cycles = 0;
  int    cur_row = 0;

  rv32_decoder dut0 (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles > MAX_CYCLES) begin
      $display("Timeout, run did not finish within %0d cycles", MAX_CYCLES);
      $display("Errors: %0d", errors);
      $display("Test FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus table
  //////////////////////////////////////////////////////////////////////
  task automatic fill_table();
    // instr, alu_sel, flags, lsu_ctrl, ra, rb, rd, imm, hold, gap
    tbl[0]  = '{32'h00500093, 4'h0, 5'b10010, 4'h0, 5'd0, 5'd0, 5'd1, 32'h5, 2'd0, 1'b0};
    tbl[1]  = '{32'hFFF08113, 4'h0, 5'b10010, 4'h0, 5'd1, 5'd0, 5'd2, 32'hFFFFFFFF, 2'd1, 1'b0};
    tbl[2]  = '{32'h401101B3, 4'h8, 5'b11010, 4'h0, 5'd2, 5'd1, 5'd3, 32'h0, 2'd1, 1'b0};
    tbl[3]  = '{32'h0020E233, 4'h6, 5'b11010, 4'h6, 5'd1, 5'd2, 5'd4, 32'h0, 2'd0, 1'b1};
    tbl[4]  = '{32'h00321293, 4'h1, 5'b10010, 4'h1, 5'd4, 5'd0, 5'd5, 32'h3, 2'd1, 1'b0};
    tbl[5]  = '{32'h41F2D313, 4'hD, 5'b10010, 4'h5, 5'd5, 5'd0, 5'd6, 32'h1F, 2'd1, 1'b0};
    tbl[6]  = '{32'h8000C393, 4'h4, 5'b10010, 4'h4, 5'd1, 5'd0, 5'd7, 32'hFFFFF800, 2'd0, 1'b0};
    tbl[7]  = '{32'h00C3A403, 4'h0, 5'b10001, 4'h2, 5'd7, 5'd0, 5'd8, 32'hC, 2'd1, 1'b0};
    tbl[8]  = '{32'hFE812E23, 4'h0, 5'b10001, 4'hA, 5'd2, 5'd8, 5'd28, 32'hFFFFFFFC, 2'd1, 1'b0};
    tbl[9]  = '{32'h000E04B3, 4'h0, 5'b11010, 4'h0, 5'd28, 5'd0, 5'd9, 32'h0, 2'd0, 1'b0};
    tbl[10] = '{32'hABCDE537, 4'h0, 5'b10010, 4'h6, 5'd0, 5'd0, 5'd10, 32'hABCDE000, 2'd0, 1'b1};
    tbl[11] = '{32'h12345597, 4'h0, 5'b10110, 4'h5, 5'd0, 5'd0, 5'd11, 32'h12345000, 2'd0, 1'b0};
    tbl[12] = '{32'h001000EF, 4'h0, 5'b00110, 4'h0, 5'd0, 5'd0, 5'd1, 32'h4, 2'd2, 1'b0};
    tbl[13] = '{32'h00708613, 4'h0, 5'b10010, 4'h0, 5'd1, 5'd0, 5'd12, 32'h7, 2'd1, 1'b0};
    tbl[14] = '{32'hFF9FF06F, 4'h0, 5'b00110, 4'h7, 5'd0, 5'd0, 5'd0, 32'h4, 2'd2, 1'b0};
    tbl[15] = '{32'h7FF61683, 4'h0, 5'b10001, 4'h1, 5'd12, 5'd0, 5'd13, 32'h7FF, 2'd0, 1'b1};
    tbl[16] = '{32'h00D682A3, 4'h0, 5'b10001, 4'h8, 5'd13, 5'd13, 5'd5, 32'h5, 2'd1, 1'b0};
    tbl[17] = '{32'h0056B733, 4'h3, 5'b11010, 4'h3, 5'd13, 5'd5, 5'd14, 32'h0, 2'd0, 1'b1};
    tbl[18] = '{32'h00208463, 4'h0, 5'b00000, 4'h0, 5'd0, 5'd0, 5'd0, 32'h0, 2'd0, 1'b0};
    for (int i = 0; i < NUM_ROWS; i++) begin
      exp_jmp[i] = '0;
    end
    exp_jmp[12] = 32'h00000800;   // Offset +2048 of jal x1
    exp_jmp[14] = 32'hFFFFFFF8;   // Offset -8 of jal x0
  endtask

  function automatic data_t row_addr(input int idx);
    return data_t'(32'h100 + idx * 4);
  endfunction

  task automatic check_val(input string name, input data_t got, input data_t exp);
    assert (got === exp) else begin
      $display("MISMATCH %s row %0d: got 0x%h, expected 0x%h", name, cur_row, got, exp);
      errors++;
    end
  endtask

  task automatic drive_row(input int idx);
    instr_i       <= tbl[idx].instr;
    instr_addr_i  <= row_addr(idx);
    instr_valid_i <= 1'b1;
  endtask

  task automatic check_strobes_low();
    check_val("use_pc_o", data_t'(use_pc_o), '0);
    check_val("alu_wb_o", data_t'(alu_wb_o), '0);
    check_val("lsu_valid_o", data_t'(lsu_valid_o), '0);
  endtask

  task automatic check_fields(input int idx);
    check_val("alu_sel_o", data_t'(alu_sel_o), data_t'(tbl[idx].alu_sel));
    check_val("alu_op_a_o", data_t'(alu_op_a_o), data_t'(tbl[idx].flags[4]));
    check_val("alu_op_b_o", data_t'(alu_op_b_o), data_t'(tbl[idx].flags[3]));
    check_val("use_pc_o", data_t'(use_pc_o), data_t'(tbl[idx].flags[2]));
    check_val("alu_wb_o", data_t'(alu_wb_o), data_t'(tbl[idx].flags[1]));
    check_val("lsu_valid_o", data_t'(lsu_valid_o), data_t'(tbl[idx].flags[0]));
    check_val("lsu_ctrl_o", data_t'(lsu_ctrl_o), data_t'(tbl[idx].lsu_ctrl));
    check_val("rf_addr_a_o", data_t'(rf_addr_a_o), data_t'(tbl[idx].ra));
    check_val("rf_addr_b_o", data_t'(rf_addr_b_o), data_t'(tbl[idx].rb));
    check_val("rd_o", data_t'(rd_o), data_t'(tbl[idx].rd));
    check_val("imm_o", imm_o, tbl[idx].imm);
    check_val("instr_addr_o", instr_addr_o, row_addr(idx));
    check_val("illegal_instr_o", data_t'(illegal_instr_o), '0);
  endtask

  // Strobes drop while the other fields keep the last issued row
  task automatic check_idle(input int idx);
    check_strobes_low();
    check_val("alu_sel_o", data_t'(alu_sel_o), data_t'(tbl[idx].alu_sel));
    check_val("rd_o", data_t'(rd_o), data_t'(tbl[idx].rd));
    check_val("imm_o", imm_o, tbl[idx].imm);
    check_val("instr_addr_o", instr_addr_o, row_addr(idx));
  endtask

  // Called at a falling edge with the row already presented
  task automatic wait_issue(input int idx);
    int hold;
    int pulses;
    hold = 0;
    pulses = 0;
    while (!ready_o) begin
      if (jmp_o) begin
        pulses++;
        check_val("jmp_addr_o", jmp_addr_o, exp_jmp[idx]);
      end
      hold++;
      @(negedge clk_i);
    end
    check_val("jmp_addr_o", jmp_addr_o, '0);   // No jump in the issue cycle
    assert (hold == int'(tbl[idx].hold)) else begin
      $display("Row %0d was held for %0d cycles instead of %0d", idx, hold, tbl[idx].hold);
      errors++;
    end
    assert (pulses == ((exp_jmp[idx] != '0) ? 1 : 0)) else begin
      $display("Row %0d gave %0d jump pulses", idx, pulses);
      errors++;
    end
    if (hold > 0) begin
      check_strobes_low();   // Bubble from the hold cycle
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////
  initial begin
    int idle;
    void'($urandom(32'h8d924c13));
    rstn_i = 1'b0;
    instr_i = '0;
    instr_addr_i = '0;
    instr_valid_i = 1'b0;
    fill_table();
    repeat (10) @(posedge clk_i);
    rstn_i <= 1'b1;
    @(posedge clk_i);
    drive_row(0);
    @(negedge clk_i);

    for (int i = 0; i < NUM_ROWS - 1; i++) begin
      cur_row = i;
      wait_issue(i);
      @(posedge clk_i);   // Issue edge
      if (tbl[i].gap) begin
        instr_valid_i <= 1'b0;
      end else begin
        drive_row(i + 1);
      end
      @(negedge clk_i);
      check_fields(i);
      if (tbl[i].gap) begin
        idle = 2 + int'($urandom % 3);
        repeat (idle - 1) begin
          @(posedge clk_i);
          @(negedge clk_i);
          check_idle(i);
        end
        @(posedge clk_i);
        drive_row(i + 1);
        @(negedge clk_i);
      end
    end

    // BRANCH is illegal and parks the decoder
    cur_row = NUM_ROWS - 1;
    repeat (6) begin
      assert (!ready_o) else begin
        $display("ready_o went high after an illegal instruction");
        errors++;
      end
      @(negedge clk_i);
    end
    check_val("illegal_instr_o", data_t'(illegal_instr_o), data_t'(1'b1));
    check_strobes_low();

    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* rv32_decoder.f */
+incdir+source
source/rv32_decoder_pkg.sv
source/imm_gen.sv
source/ctrl_decode.sv
source/hazard_fsm.sv
source/id_ex_regs.sv
source/rv32_decoder.sv
tests/tb_rv32_decoder.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_rv32_decoder -f rv32_decoder.f \
  --Mdir obj_dir -o sim_tb

output=$(./obj_dir/sim_tb)
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "Test OK"; then
  exit 0
fi
exit 1
